/* hw/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer import sprite_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  raster_t    raster,
  input  pix_wr_t    pix_wr,
  output logic [3:0] rgb
);

  logic [3:0] mem [2*h_display]; // {half, col}
  logic [1:0] clean_q;           // half fully swept since reset
  logic       rd_half;
  logic       rd_on;
  logic [8:0] rd_addr;
  logic [8:0] wr_addr;

  assign rd_half = raster.vpos[0];
  assign rd_on   = !raster.hpos[8]; // columns 0..255
  assign rd_addr = {rd_half, raster.hpos[7:0]};
  assign wr_addr = {~rd_half, pix_wr.col}; // paint the other half

  // halves never collide, write and clear in one clock
  always_ff @(posedge clk) begin
    if (pix_wr.en) begin
      mem[wr_addr] <= pix_wr.color;
    end
    if (rd_on) begin
      mem[rd_addr] <= 4'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rgb     <= 4'd0;
      clean_q <= 2'b00;
    end else begin
      rgb <= (rd_on && clean_q[rd_half]) ? mem[rd_addr] : 4'd0;
      if (raster.hpos == 9'(h_display - 1)) begin
        clean_q[rd_half] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/line_selector.sv */
`timescale 1ns/1ps
`default_nettype none

module line_selector import sprite_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  phase_e     phase,
  input  wire        pair,
  input  wire        line_start,
  input  raster_t    raster,
  output logic [4:0] rd_index,
  input  sprite_t    rd_sprite,
  output slot_t [num_slots-1:0] slots
);

  logic [4:0]  spr_cnt;  // sprite under test
  logic [3:0]  slot_cnt; // filled slots, up to num_slots
  logic [7:0]  yofs_q;   // vpos minus ypos, mod 256
  logic [num_slots-1:0] act_q;
  slot_t       slot_q [num_slots];
  logic        sel_even;
  logic        sel_odd;
  logic        hit;

  assign rd_index = spr_cnt;
  assign sel_even = (phase == ph_select) && !pair;
  assign sel_odd  = (phase == ph_select) && pair;

  // crosses this line and there is still room
  assign hit = rd_sprite.valid && (yofs_q < 8'd16) && (slot_cnt < 4'(num_slots));

  always_ff @(posedge clk) begin
    if (sel_even) begin
      yofs_q <= raster.vpos[7:0] - rd_sprite.ypos;
    end
    if (sel_odd && hit) begin
      slot_q[slot_cnt[2:0]] <= '{active: 1'b1,
                                 xpos:   rd_sprite.xpos,
                                 yofs:   yofs_q[3:0],
                                 shape:  rd_sprite.shape,
                                 color:  rd_sprite.color};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spr_cnt  <= '0;
      slot_cnt <= '0;
      act_q    <= '0;
    end else if (line_start) begin
      spr_cnt  <= '0;
      slot_cnt <= '0;
      act_q    <= '0;
    end else if (sel_odd) begin
      if (hit) begin
        act_q[slot_cnt[2:0]] <= 1'b1;
        slot_cnt             <= slot_cnt + 4'd1;
      end
      spr_cnt <= spr_cnt + 5'd1; // wraps to 0 after sprite 31
    end
  end

  always_comb begin
    for (int k = 0; k < num_slots; k++) begin
      slots[k]        = slot_q[k];
      slots[k].active = act_q[k]; // payload has no reset
    end
  end

  // slots fill in order, so active count tracks the counter
  a_slot_count: assert property (@(posedge clk) disable iff (!rst_n)
    (slot_cnt <= 4'(num_slots)) && ($countones(act_q) == int'(slot_cnt)));

endmodule

`default_nettype wire

/* hw/render_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module render_sequencer import sprite_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  input  raster_t raster,
  output phase_e  phase,
  output logic [4:0] step,
  output logic    pair,
  output logic    line_start
);

  logic       line_end;
  logic [8:0] v_next;

  assign line_end = (raster.hpos == 9'(h_total - 1));
  assign v_next   = (raster.vpos == 9'(v_total - 1)) ? 9'd0 : raster.vpos + 9'd1;

  // rendered lines are 0..255, vpos bit 8 marks blank ones
  always_comb begin
    if (raster.vpos == 9'(load_line) && raster.hpos < 9'(load_end)) begin
      phase = ph_load;
    end else if (!raster.vpos[8] && raster.hpos < 9'(select_end)) begin
      phase = ph_select;
    end else if (!raster.vpos[8] && raster.hpos < 9'(paint_end)) begin
      phase = ph_paint;
    end else begin
      phase = ph_idle;
    end
  end

  // two clocks per sprite: step picks the sprite, pair the half
  assign step = raster.hpos[5:1];
  assign pair = raster.hpos[0];

  // set on the last clock so the pulse sits on hpos 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_start <= 1'b0;
    end else begin
      line_start <= line_end && !v_next[8];
    end
  end

  a_phase_known: assert property (@(posedge clk) disable iff (!rst_n)
    phase inside {ph_load, ph_select, ph_paint, ph_idle});

  // the line clear must land inside select
  a_start_in_select: assert property (@(posedge clk) disable iff (!rst_n)
    line_start |-> (phase == ph_select && step == 5'd0 && !pair));

endmodule

`default_nettype wire

/* hw/sprite_painter.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_painter import sprite_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  phase_e     phase,
  input  wire        line_start,
  input  slot_t [num_slots-1:0] slots,
  output logic [7:0] rom_addr,
  input  wire [15:0] rom_data,
  output pix_wr_t    pix_wr
);

  logic [15:0] bits_q;  // bitmap row, lsb is the next column
  logic [8:0]  col_q;   // one extra bit to see the right edge
  logic [3:0]  color_q;
  logic [3:0]  k_q;     // slot index, num_slots when done
  logic        fetch_q; // rom_addr holds slot k
  logic        busy;
  logic        more;
  slot_t       cur;

  assign cur  = slots[k_q[2:0]];
  assign busy = (bits_q != 16'd0);
  assign more = (k_q < 4'(num_slots));

  // datapath: rom address, start column, colour
  always_ff @(posedge clk) begin
    if (phase == ph_paint) begin
      if (busy) begin
        col_q <= col_q + 9'd1;
      end else if (more) begin
        if (!fetch_q) begin
          rom_addr <= {cur.shape, cur.yofs};
        end else begin
          col_q   <= {1'b0, cur.xpos};
          color_q <= cur.color;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bits_q  <= '0;
      k_q     <= '0;
      fetch_q <= 1'b0;
      pix_wr  <= '0;
    end else begin
      pix_wr.en <= 1'b0;
      if (line_start) begin
        bits_q  <= '0;
        k_q     <= '0;
        fetch_q <= 1'b0;
      end else if (phase == ph_paint) begin
        if (busy) begin
          // one column per clock, drop anything past 255
          pix_wr.en    <= bits_q[0] && !col_q[8];
          pix_wr.col   <= col_q[7:0];
          pix_wr.color <= color_q;
          bits_q       <= bits_q >> 1;
        end else if (more) begin
          if (fetch_q) begin
            bits_q <= cur.active ? rom_data : 16'd0; // rom settled by now
            k_q    <= k_q + 4'd1;
          end
          fetch_q <= !fetch_q;
        end
      end
    end
  end

  // clipped columns never reach the buffer
  a_clip: assert property (@(posedge clk) disable iff (!rst_n)
    pix_wr.en |-> !$past(col_q[8]));

endmodule

`default_nettype wire

/* hw/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

  // raster geometry in clocks and lines
  localparam int h_display    = 256;
  localparam int h_total      = 309;
  localparam int h_sync_start = 263;
  localparam int h_sync_end   = 286; // exclusive
  localparam int v_display    = 240;
  localparam int v_total      = 262;
  localparam int v_sync_start = 245;
  localparam int v_sync_end   = 248; // exclusive
  localparam int load_line    = 260; // attribute copy line

  localparam int num_sprites  = 32;
  localparam int num_slots    = 8;  // sprites per line

  // phase boundaries on hpos
  localparam int select_end   = 64;  // 2 cycles per sprite
  localparam int paint_end    = 208; // 8 slots x 18 cycles
  localparam int load_end     = 72;  // 64 plus spare

  typedef enum logic [1:0] {
    ph_load,   // copy attributes from ram
    ph_select, // pick sprites for the line
    ph_paint,  // fetch rows and write the buffer
    ph_idle
  } phase_e;

  typedef struct packed {
    logic [8:0] hpos;
    logic [8:0] vpos;
  } raster_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] xpos;
    logic [7:0] ypos;
    logic [3:0] shape; // bitmap rom page
    logic [3:0] color;
  } sprite_t;

  typedef struct packed {
    logic       active;
    logic [7:0] xpos;
    logic [3:0] yofs; // row inside the bitmap
    logic [3:0] shape;
    logic [3:0] color;
  } slot_t;

  typedef struct packed {
    logic       en;
    logic [7:0] col;
    logic [3:0] color;
  } pix_wr_t;

endpackage

`default_nettype wire

/* hw/sprite_render_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_render_top import sprite_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  output logic [5:0] ram_addr,
  input  wire [15:0] ram_data,
  output logic       ram_busy,
  output logic [7:0] rom_addr,
  input  wire [15:0] rom_data,
  output logic       hsync,
  output logic       vsync,
  output logic       display_on,
  output logic [3:0] rgb
);

  raster_t    raster;
  phase_e     phase;
  logic [4:0] step;
  logic       pair;
  logic       line_start;
  logic [4:0] rd_index;
  sprite_t    rd_sprite;
  slot_t [num_slots-1:0] slots;
  pix_wr_t    pix_wr;

  video_timing timing_i (
    .clk, .rst_n, .raster, .hsync, .vsync, .display_on
  );

  render_sequencer seq_i (
    .clk, .rst_n, .raster, .phase, .step, .pair, .line_start
  );

  // attribute copy, once a frame
  sprite_table table_i (
    .clk, .rst_n, .phase, .step, .pair,
    .ram_addr, .ram_data, .ram_busy, .rd_index, .rd_sprite
  );

  line_selector sel_i (
    .clk, .rst_n, .phase, .pair, .line_start, .raster,
    .rd_index, .rd_sprite, .slots
  );

  sprite_painter paint_i (
    .clk, .rst_n, .phase, .line_start, .slots,
    .rom_addr, .rom_data, .pix_wr
  );

  line_buffer buf_i (
    .clk, .rst_n, .raster, .pix_wr, .rgb
  );

endmodule

`default_nettype wire

/* hw/sprite_table.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_table import sprite_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  phase_e     phase,
  input  wire [4:0]  step,
  input  wire        pair,
  output logic [5:0] ram_addr,
  input  wire [15:0] ram_data,
  output logic       ram_busy,
  input  wire [4:0]  rd_index,
  output sprite_t    rd_sprite
);

  logic [15:0] pos_q  [num_sprites]; // ypos high, xpos low
  logic [7:0]  attr_q [num_sprites]; // shape high, color low
  logic [num_sprites-1:0] vld_q;

  // address to capture delay, ram is one clock behind ram_addr
  logic       d1_load;
  logic       d2_load;
  logic [4:0] d1_idx;
  logic [4:0] d2_idx;
  logic       d1_pair;
  logic       d2_pair;

  assign ram_busy = (phase == ph_load);

  always_ff @(posedge clk) begin
    if (ram_busy) begin
      ram_addr <= {step, pair}; // word 2i or 2i+1
    end
    d1_idx  <= step;
    d1_pair <= pair;
    d2_idx  <= d1_idx;
    d2_pair <= d1_pair;
    if (d2_load) begin
      if (d2_pair) begin
        attr_q[d2_idx] <= ram_data[7:0];
      end else begin
        pos_q[d2_idx] <= ram_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d1_load <= 1'b0;
      d2_load <= 1'b0;
      vld_q   <= '0;
    end else begin
      d1_load <= ram_busy;
      d2_load <= d1_load;
      if (d2_load && d2_pair) begin
        vld_q[d2_idx] <= 1'b1; // second word done
      end
    end
  end

  // combinational read for the selector
  assign rd_sprite = '{valid: vld_q[rd_index],
                       xpos:  pos_q[rd_index][7:0],
                       ypos:  pos_q[rd_index][15:8],
                       shape: attr_q[rd_index][7:4],
                       color: attr_q[rd_index][3:0]};

  // copy always starts on word 0 of sprite 0
  a_load_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ram_busy) |-> (step == 5'd0 && !pair));

endmodule

`default_nettype wire

/* hw/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing import sprite_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  output raster_t raster,
  output logic    hsync,
  output logic    vsync,
  output logic    display_on
);

  logic       h_wrap; // last clock of the line
  logic [8:0] h_next;
  logic [8:0] v_next;

  assign h_wrap = (raster.hpos == 9'(h_total - 1));
  assign h_next = h_wrap ? 9'd0 : raster.hpos + 9'd1;

  always_comb begin
    v_next = raster.vpos;
    if (h_wrap) begin
      // frame wrap after the last blank line
      v_next = (raster.vpos == 9'(v_total - 1)) ? 9'd0 : raster.vpos + 9'd1;
    end
  end

  // outputs decoded from the next position so they line up with raster
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      raster     <= '0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      display_on <= 1'b0;
    end else begin
      raster.hpos <= h_next;
      raster.vpos <= v_next;
      hsync       <= (h_next >= 9'(h_sync_start)) && (h_next < 9'(h_sync_end));
      vsync       <= (v_next >= 9'(v_sync_start)) && (v_next < 9'(v_sync_end));
      display_on  <= (h_next < 9'(h_display)) && (v_next < 9'(v_display));
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the sprite renderer testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module sprite_render_tb \
  -f sprite_render.f -o sprite_render_sim \
  && { out=$(./obj_dir/sprite_render_sim); echo "$out"; } \
  && echo "$out" | grep -q "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sprite_render.f */
hw/sprite_pkg.sv
hw/video_timing.sv
hw/render_sequencer.sv
hw/sprite_table.sv
hw/line_selector.sv
hw/sprite_painter.sv
hw/line_buffer.sv
hw/sprite_render_top.sv
test/sprite_render_tb.sv

/* test/sprite_render_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_render_tb import sprite_pkg::*; ();

  logic        clk = 1'b0;
  logic        rst_n;
  logic [5:0]  ram_addr;
  logic [15:0] ram_data = '0;
  logic        ram_busy;
  logic [7:0]  rom_addr;
  logic [15:0] rom_data;
  logic        hsync;
  logic        vsync;
  logic        display_on;
  logic [3:0]  rgb;

  logic [15:0] ram [64];  // attribute words, two per sprite
  logic [15:0] rom [256]; // bitmap rows, {shape, row}
  logic [15:0] ref_pos  [num_sprites]; // copy taken after each load line
  logic [7:0]  ref_attr [num_sprites];
  logic        ref_loaded;

  int    h_cnt = 0;     // tb's own raster position
  int    v_cnt = 0;
  int    frame_cnt = 0;
  int    cur_h;         // position shown in error lines
  int    cur_v;
  int    prev_h;
  int    prev_v;
  logic  prev_vis = 1'b0;
  logic  started = 1'b0;
  int    err_cnt = 0;
  string test_name;

  sprite_render_top dut_i (
    .clk, .rst_n, .ram_addr, .ram_data, .ram_busy, .rom_addr, .rom_data,
    .hsync, .vsync, .display_on, .rgb
  );

  always #50 clk = ~clk; // 100 ns period

  // synchronous ram, one clock of latency
  always @(posedge clk) begin
    ram_data <= #1 ram[ram_addr];
  end

  assign rom_data = rom[rom_addr]; // combinational rom

  always @(posedge clk) begin
    if (!rst_n) begin
      h_cnt     <= 0;
      v_cnt     <= 0;
      frame_cnt <= 0;
    end else if (h_cnt == h_total - 1) begin
      h_cnt <= 0;
      if (v_cnt == v_total - 1) begin
        v_cnt     <= 0;
        frame_cnt <= frame_cnt + 1;
      end else begin
        v_cnt <= v_cnt + 1;
      end
    end else begin
      h_cnt <= h_cnt + 1;
    end
  end

  task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("FAILED %s %s at x=%0d y=%0d expected %0h actual %0h",
               test_name, name, cur_h, cur_v, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic place_sprite(int i, logic [7:0] x, logic [7:0] y, logic [3:0] shape,
                              logic [3:0] color);
    logic [5:0] a;
    a              = 6'(2 * i);
    ram[a]         = {y, x};                   // ypos high, xpos low
    ram[a + 6'd1]  = {8'h00, shape, color};
  endtask

  // every sprite parked below the visible lines
  task automatic hide_sprites();
    for (int i = 0; i < num_sprites; i++) begin
      place_sprite(i, 8'(i * 8), 8'd240, 4'(i), 4'(i));
    end
  endtask

  task automatic wait_line(int f, int l);
    while (!(frame_cnt == f && v_cnt == l)) begin
      @(posedge clk);
      #1;
    end
  endtask

  // colour at column x of line v, painted while line v-1 ran
  function automatic logic [3:0] expected_pixel(int x, int v);
    logic [3:0]  c;
    logic [4:0]  ix;
    logic [7:0]  yofs;
    logic [15:0] row;
    int          cnt;
    int          b;
    c   = 4'd0;
    cnt = 0;
    if (v == 0 || !ref_loaded) begin
      return 4'd0; // line 261 paints nothing
    end
    for (int i = 0; i < num_sprites; i++) begin
      ix   = 5'(i);
      yofs = 8'(v - 1) - ref_pos[ix][15:8];
      if (yofs < 8'd16 && cnt < num_slots) begin
        cnt++;
        row = rom[{ref_attr[ix][7:4], yofs[3:0]}];
        b   = x - int'(ref_pos[ix][7:0]);
        if (b >= 0 && b < 16 && row[4'(b)]) begin
          c = ref_attr[ix][3:0]; // later index wins
        end
      end
    end
    return c;
  endfunction

  // rom address held on the clock the painter loads a row of line l
  function automatic bit expected_fetch(int h, int l, output logic [7:0] addr);
    logic [7:0]  yofs;
    logic [15:0] row;
    int          t;
    int          cnt;
    int          len;
    addr = 8'd0;
    t    = select_end; // first address clock of the paint phase
    cnt  = 0;
    if (!ref_loaded) begin
      return 1'b0; // nothing valid yet
    end
    for (int i = 0; i < num_sprites; i++) begin
      yofs = 8'(l) - ref_pos[5'(i)][15:8];
      if (yofs < 8'd16 && cnt < num_slots) begin
        cnt++;
        addr = {ref_attr[5'(i)][7:4], yofs[3:0]};
        if (h == t + 1) begin
          return 1'b1;
        end
        row = rom[addr];
        len = 0;
        for (int b = 0; b < 16; b++) begin
          if (row[4'(b)]) begin
            len = b + 1; // shifts until the top set bit is out
          end
        end
        t = t + 2 + len;
      end
    end
    return 1'b0;
  endfunction

  // compare on the falling edge, all outputs settled
  always @(negedge clk) begin
    logic [7:0] exp_addr;
    bit         fetch_now;
    if (rst_n) begin
      cur_h = h_cnt;
      cur_v = v_cnt;
      check_value("hsync", 16'(h_cnt >= h_sync_start && h_cnt < h_sync_end), 16'(hsync));
      check_value("vsync", 16'(v_cnt >= v_sync_start && v_cnt < v_sync_end), 16'(vsync));
      check_value("ram_busy", 16'(v_cnt == load_line && h_cnt < load_end), 16'(ram_busy));
      if (v_cnt == load_line && h_cnt >= 1 && h_cnt <= 64) begin
        check_value("ram_addr", 16'(h_cnt - 1), 16'(ram_addr)); // issued one clock ago
      end
      if (v_cnt < 256) begin
        fetch_now = expected_fetch(h_cnt, v_cnt, exp_addr);
        if (fetch_now) begin
          check_value("rom_addr", 16'(exp_addr), 16'(rom_addr));
        end
      end
      if (started) begin
        check_value("display_on", 16'(h_cnt < h_display && v_cnt < v_display),
                    16'(display_on));
      end
      if (prev_vis) begin
        cur_h = prev_h; // rgb lags its column by one clock
        cur_v = prev_v;
        check_value("rgb", 16'(expected_pixel(prev_h, prev_v)), 16'(rgb));
      end
      prev_vis = display_on;
      prev_h   = h_cnt;
      prev_v   = v_cnt;
      started  = 1'b1;
      if (v_cnt == v_total - 1 && h_cnt == 0) begin
        for (int i = 0; i < num_sprites; i++) begin
          ref_pos[5'(i)]  = ram[6'(2 * i)];     // what line 260 copied
          ref_attr[5'(i)] = ram[6'(2 * i + 1)][7:0];
        end
        ref_loaded = 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] tmp;
    rst_n      = 1'b0;
    ref_loaded = 1'b0;
    test_name  = "reset_blank";
    void'($urandom(65326));
    for (int i = 0; i < 256; i++) begin
      tmp            = $urandom();
      rom[8'(i)]     = tmp[15:0];
    end
    hide_sprites();
    tmp = $urandom();
    place_sprite(0, 8'(16 + tmp[6:0]), 8'(20 + tmp[14:8]), tmp[19:16],
                 4'(1 + tmp[22:20])); // random spot and shape
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    wait_line(1, 0);
    test_name = "single_sprite";
    hide_sprites();
    for (int i = 0; i < 10; i++) begin
      place_sprite(i, 8'(20 + 6 * i), 8'd100, 4'(i), 4'(i + 1)); // one band, overlapping
    end

    wait_line(2, 0);
    test_name = "slot_limit";
    hide_sprites();
    place_sprite(0, 8'd250, 8'd30, 4'd3, 4'd9);  // runs past column 255
    place_sprite(1, 8'd241, 8'd60, 4'd7, 4'd12);
    place_sprite(2, 8'd0, 8'd30, 4'd11, 4'd6);   // would show any wraparound

    wait_line(3, 0);
    test_name = "clip_right";
    place_sprite(0, 8'd120, 8'd200, 4'd3, 4'd9);
    place_sprite(1, 8'd5, 8'd10, 4'd7, 4'd12);
    place_sprite(2, 8'd200, 8'd0, 4'd11, 4'd6);
    place_sprite(3, 8'd60, 8'd250, 4'd5, 4'd14); // wraps in from the top
    place_sprite(4, 8'd90, 8'd230, 4'd2, 4'd3);  // cut at the bottom

    wait_line(4, 0);
    test_name = "move_sprites";
    wait_line(4, v_display); // last visible line checked
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // five frames cover every test
  initial begin
    int limit;
    limit = 5 * h_total * v_total + 2000;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within five frames");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
